// ==== compile.f ====
+incdir+include
logic/gps_chan_pkg.sv
logic/gps_panel_pkg.sv
logic/chan_report_if.sv
logic/sample_clk_div.sv
logic/track_ready_stretch.sv
logic/status_regs_axil.sv
logic/hex_page_display.sv
logic/gps_status_panel.sv
dv/gps_panel_checker.sv
dv/gps_panel_tb.sv

// ==== Makefile ====
TOP := gps_panel_tb

all: run

build:
	verilator --binary --timing --assert -Wno-fatal -f compile.f \
		--top-module $(TOP) -Mdir obj_dir -o sim

run: build
	./obj_dir/sim > sim.log 2>&1 || true
	cat sim.log
	@if grep -q "TESTS FAILED" sim.log; then echo "Simulation reported failure"; exit 1; fi
	@grep -q "TESTS PASSED" sim.log || (echo "Simulation ended without a result"; exit 1)

lint:
	verilator --lint-only -Wall --timing -f compile.f --top-module $(TOP)

clean:
	rm -rf obj_dir sim.log

.PHONY: all build run lint clean

// ==== dv/gps_panel_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

module gps_panel_tb;

   localparam int WAIT_LIMIT = 60;
   // Active-high segment patterns gfedcba for 0..F
   localparam logic [6:0] SEGS_ON [16] = '{7'h3F, 7'h06, 7'h5B, 7'h4F, 7'h66, 7'h6D,
      7'h7D, 7'h07, 7'h7F, 7'h6F, 7'h77, 7'h7C, 7'h39, 7'h5E, 7'h79, 7'h71};

   logic                      clk_16_8 = 1'b0;
   logic                      rst_n;
   gps_chan_pkg::rx_mode_e    mode;
   logic                      tracking_ready;
   logic [17:0]               sw;
   gps_chan_pkg::iq_t         i_prompt, q_prompt;
   gps_chan_pkg::i2q2_t       i2q2_early, i2q2_prompt, i2q2_late, acq_peak_i2q2;
   gps_chan_pkg::dphi_t       carrier_dphi, ca_dphi, acq_peak_doppler;
   gps_chan_pkg::code_shift_t acq_peak_code_shift, code_shift;
   logic [31:0]               sample_count;
   logic                      acquisition_complete;
   logic [7:0]                araddr;
   logic                      arvalid, arready, rvalid, rready;
   logic [31:0]               rdata;
   logic [1:0]                rresp;
   gps_panel_pkg::seg7_t      hex_out [8];
   logic [17:0]               ledr;
   logic [2:0]                ledg;

   int value_errs = 0;
   int other_errs = 0;
   int sclk_edges = 0;  // Edges since reset release
   int flag_left  = 0;  // Expected remaining high samples of the ready flag

   always #50 clk_16_8 = ~clk_16_8;

   gps_status_panel dut_i (
      .clk_16_8(clk_16_8), .rst_n(rst_n), .mode(mode), .tracking_ready(tracking_ready),
      .sw(sw), .i_prompt(i_prompt), .q_prompt(q_prompt), .i2q2_early(i2q2_early),
      .i2q2_prompt(i2q2_prompt), .i2q2_late(i2q2_late), .carrier_dphi(carrier_dphi),
      .ca_dphi(ca_dphi), .acq_peak_i2q2(acq_peak_i2q2), .acq_peak_doppler(acq_peak_doppler),
      .acq_peak_code_shift(acq_peak_code_shift), .code_shift(code_shift),
      .sample_count(sample_count), .acquisition_complete(acquisition_complete),
      .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata),
      .rresp(rresp), .rvalid(rvalid), .rready(rready),
      .hex0(hex_out[0]), .hex1(hex_out[1]), .hex2(hex_out[2]), .hex3(hex_out[3]),
      .hex4(hex_out[4]), .hex5(hex_out[5]), .hex6(hex_out[6]), .hex7(hex_out[7]),
      .ledr(ledr), .ledg(ledg)
   );

   bind status_regs_axil gps_panel_checker checker_i (
      .clk_16_8(clk_16_8), .rst_n(rst_n), .arready(arready), .rvalid(rvalid),
      .rready(rready), .rdata(rdata), .rresp(rresp)
   );

   task automatic check_seg(input string what, input gps_panel_pkg::seg7_t got,
                            input gps_panel_pkg::seg7_t exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_word(input string what, input logic [`AXIL_DATA_WIDTH-1:0] got,
                             input logic [`AXIL_DATA_WIDTH-1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s got %h expected %h", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_resp(input string what, input logic [1:0] got, input logic [1:0] exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
         value_errs++;
      end
   endtask

   task automatic check_bit(input string what, input logic got, input logic exp);
      if (got !== exp) begin
         $display("Fail at %0t: %s got %b expected %b", $time, what, got, exp);
         value_errs++;
      end
   endtask

   // One clock: advance the divider and stretcher models, then check both LEDs
   task automatic step();
      logic exp_sclk;
      @(posedge clk_16_8);
      if (!rst_n) begin
         sclk_edges = 0;
         flag_left  = 0;
      end else begin
         sclk_edges++;
         if (tracking_ready && (mode == gps_chan_pkg::MODE_TRACK || flag_left > 0))
            flag_left = `READY_HOLD + 1;  // Set, or hold restarted while high
         else if (flag_left > 0)
            flag_left--;
      end
      #5;
      exp_sclk = ((sclk_edges / (`SAMPLE_DIV_RELOAD + 1)) % 2) == 1;
      if (rst_n) begin
         check_bit("clk_sample on ledg[1]", ledg[1], exp_sclk);
         check_bit("ready flag on ledg[0]", ledg[0], flag_left > 0);
      end
   endtask

   task automatic randomize_chan();
      i_prompt             = 18'($urandom);
      q_prompt             = 18'($urandom);
      i2q2_early           = 38'({$urandom, $urandom});
      i2q2_prompt          = 38'({$urandom, $urandom});
      i2q2_late            = 38'({$urandom, $urandom});
      acq_peak_i2q2        = 38'({$urandom, $urandom});
      carrier_dphi         = 17'($urandom);
      ca_dphi              = 17'($urandom);
      acq_peak_doppler     = 17'($urandom);
      acq_peak_code_shift  = 15'($urandom);
      code_shift           = 15'($urandom);
      sample_count         = $urandom;
      acquisition_complete = 1'($urandom);
   endtask

   function automatic gps_panel_pkg::disp_page_e model_page(input logic [17:0] s);
      if (s[4])
         return gps_panel_pkg::PAGE_SAMPLE_COUNT;
      if (s[14]) begin
         if (s[13:12] == 2'd1)
            return gps_panel_pkg::PAGE_ACQ_DOPPLER;
         if (s[13:12] == 2'd2)
            return gps_panel_pkg::PAGE_ACQ_CODE;
         return gps_panel_pkg::PAGE_ACQ_I2Q2;
      end
      if (s[15])
         return gps_panel_pkg::PAGE_CODE_SHIFT;
      return gps_panel_pkg::PAGE_IQ;
   endfunction

   function automatic logic [31:0] page_value(input gps_panel_pkg::disp_page_e page);
      case (page)
         gps_panel_pkg::PAGE_SAMPLE_COUNT: return sample_count;
         gps_panel_pkg::PAGE_ACQ_I2Q2:     return acq_peak_i2q2[37:6];
         gps_panel_pkg::PAGE_ACQ_DOPPLER:  return {15'd0, acq_peak_doppler};
         gps_panel_pkg::PAGE_ACQ_CODE:     return {17'd0, acq_peak_code_shift};
         gps_panel_pkg::PAGE_CODE_SHIFT:   return {17'd0, code_shift};
         default:                          return {14'd0, sw[16] ? q_prompt : i_prompt};
      endcase
   endfunction

   function automatic logic digit_blank(input gps_panel_pkg::disp_page_e page, input int d);
      if (d >= 5)
         return !(page == gps_panel_pkg::PAGE_SAMPLE_COUNT ||
                  page == gps_panel_pkg::PAGE_ACQ_I2Q2);
      if (d == 4)
         return page == gps_panel_pkg::PAGE_CODE_SHIFT ||
                page == gps_panel_pkg::PAGE_ACQ_CODE;
      return 1'b0;
   endfunction

   // Register map, returns the word and the response code
   function automatic logic [31:0] reg_model(input logic [7:0] addr, input logic flag,
                                             output logic [1:0] resp);
      resp = 2'b00;
      if (addr[1:0] != 2'b00 || addr >= 8'h20) begin
         resp = 2'b10;  // SLVERR
         return 32'd0;
      end
      case (addr[4:2])
         3'd0:    return {30'd0, acquisition_complete, flag};
         3'd1:    return {14'd0, i_prompt};
         3'd2:    return {14'd0, q_prompt};
         3'd3:    return i2q2_early[37:6];
         3'd4:    return i2q2_prompt[37:6];
         3'd5:    return i2q2_late[37:6];
         3'd6:    return {15'd0, carrier_dphi};
         default: return {15'd0, ca_dphi};
      endcase
   endfunction

   task automatic check_display();
      gps_panel_pkg::disp_page_e page;
      logic [31:0]               value;
      gps_panel_pkg::seg7_t      exp_seg;
      randomize_chan();
      sw = 18'($urandom);
      #10;
      page  = model_page(sw);
      value = page_value(page);
      for (int d = 0; d < 8; d++) begin
         exp_seg = digit_blank(page, d) ? 7'h7F : ~SEGS_ON[value[4*d +: 4]];
         check_seg($sformatf("hex%0d on page %s", d, page.name()), hex_out[d], exp_seg);
      end
      check_word("ledr prompt sum", 32'(ledr), {14'd0, sw[16] ? q_prompt : i_prompt});
      check_bit("acquisition_complete on ledg[2]", ledg[2], acquisition_complete);
   endtask

   task automatic axil_read(input logic [7:0] addr, input int stall);
      logic [31:0] exp_data;
      logic [31:0] held_data;
      logic [1:0]  exp_resp;
      logic [1:0]  held_resp;
      int          n;
      araddr  = addr;
      arvalid = 1'b1;
      n = 0;
      while (!arready && n < WAIT_LIMIT) begin
         step();
         n++;
      end
      if (!arready) begin
         $display("Timeout at %0t: arready never rose for address %h", $time, addr);
         other_errs++;
         arvalid = 1'b0;
         return;
      end
      exp_data = reg_model(addr, flag_left > 0, exp_resp);
      step();  // Handshake edge
      arvalid = 1'b0;
      check_bit("rvalid one cycle after handshake", rvalid, 1'b1);
      check_word($sformatf("rdata at %h", addr), rdata, exp_data);
      check_resp($sformatf("rresp at %h", addr), rresp, exp_resp);
      held_data = rdata;
      held_resp = rresp;
      repeat (stall) begin
         arvalid = 1'b1;  // Competing request while the response waits
         araddr  = 8'($urandom);
         step();
         check_bit("rvalid under back-pressure", rvalid, 1'b1);
         check_bit("arready under back-pressure", arready, 1'b0);
         check_word("rdata under back-pressure", rdata, held_data);
         check_resp("rresp under back-pressure", rresp, held_resp);
      end
      arvalid = 1'b0;
      rready  = 1'b1;
      step();
      rready = 1'b0;
      check_bit("rvalid after rready", rvalid, 1'b0);
      check_bit("arready after response", arready, 1'b1);
   endtask

   initial begin
      int         n;
      logic       prev;
      logic [7:0] addr;
      void'($urandom(39));
      rst_n          = 1'b0;
      mode           = gps_chan_pkg::MODE_ACQ;
      tracking_ready = 1'b0;
      sw             = '0;
      araddr         = '0;
      arvalid        = 1'b0;
      rready         = 1'b0;
      randomize_chan();
      repeat (10) step();
      rst_n = 1'b1;

      // Sample clock from reset release
      step();
      n = 1;
      check_bit("arready after reset", arready, 1'b1);
      while (!ledg[1] && n < WAIT_LIMIT) begin
         step();
         n++;
      end
      if (!ledg[1]) begin
         $display("Timeout at %0t: clk_sample never rose after reset", $time);
         other_errs++;
      end else if (n != `SAMPLE_DIV_RELOAD + 1) begin
         $display("Fail at %0t: clk_sample rose after %0d cycles", $time, n);
         value_errs++;
      end
      repeat (4) begin
         prev = ledg[1];
         n = 0;
         while (ledg[1] == prev && n < WAIT_LIMIT) begin
            step();
            n++;
         end
         if (n != `SAMPLE_DIV_RELOAD + 1) begin
            $display("Fail at %0t: clk_sample half period of %0d cycles", $time, n);
            value_errs++;
         end
      end

      // Stretcher in tracking, then in acquisition
      mode = gps_chan_pkg::MODE_TRACK;
      tracking_ready = 1'b1;
      step();
      tracking_ready = 1'b0;
      n = 0;
      while (ledg[0] && n < WAIT_LIMIT) begin
         n++;
         step();
      end
      if (n != `READY_HOLD + 1) begin
         $display("Fail at %0t: ready flag high for %0d cycles", $time, n);
         value_errs++;
      end
      mode = gps_chan_pkg::MODE_ACQ;
      tracking_ready = 1'b1;
      step();
      tracking_ready = 1'b0;
      repeat (20) step();

      repeat (64) begin
         check_display();
         step();
      end

      for (int i = 0; i < 48; i++) begin
         randomize_chan();
         mode           = gps_chan_pkg::rx_mode_e'($urandom % 2);
         tracking_ready = ($urandom % 3) == 0;
         step();
         tracking_ready = 1'b0;
         addr = (i < 8) ? 8'(i * 4) : 8'(($urandom % 8) * 4);
         axil_read(addr, $urandom % 6);
      end

      // Misaligned or past the last register
      repeat (16) begin
         addr = 8'($urandom);
         if (addr[1:0] == 2'b00 && addr[7:5] == 3'b000)
            addr[7] = 1'b1;
         axil_read(addr, $urandom % 3);
      end

      $display("Errors: %0d value mismatches, %0d other failures", value_errs, other_errs);
      if (value_errs == 0 && other_errs == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

`default_nettype wire

// ==== dv/gps_panel_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

module gps_panel_checker (
   input logic                        clk_16_8,
   input logic                        rst_n,
   input logic                        arready,
   input logic                        rvalid,
   input logic                        rready,
   input logic [`AXIL_DATA_WIDTH-1:0] rdata,
   input logic [1:0]                  rresp
);

   // Response must wait for the host
   rvalid_held: assert property (@(posedge clk_16_8) disable iff (!rst_n)
      rvalid && !rready |=> rvalid)
      else $error("rvalid dropped before rready");

   rdata_stable: assert property (@(posedge clk_16_8) disable iff (!rst_n)
      rvalid && !rready |=> $stable(rdata) && $stable(rresp))
      else $error("rdata or rresp changed under back-pressure");

   // Single read in flight
   no_second_read: assert property (@(posedge clk_16_8) disable iff (!rst_n)
      rvalid |-> !arready)
      else $error("arready high while a response is pending");

endmodule

`default_nettype wire

// ==== logic/gps_status_panel.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

module gps_status_panel (
   input  logic                        clk_16_8,
   input  logic                        rst_n,
   input  gps_chan_pkg::rx_mode_e      mode,
   input  logic                        tracking_ready,
   input  logic [17:0]                 sw,
   input  gps_chan_pkg::iq_t           i_prompt,
   input  gps_chan_pkg::iq_t           q_prompt,
   input  gps_chan_pkg::i2q2_t         i2q2_early,
   input  gps_chan_pkg::i2q2_t         i2q2_prompt,
   input  gps_chan_pkg::i2q2_t         i2q2_late,
   input  gps_chan_pkg::dphi_t         carrier_dphi,
   input  gps_chan_pkg::dphi_t         ca_dphi,
   input  gps_chan_pkg::i2q2_t         acq_peak_i2q2,
   input  gps_chan_pkg::dphi_t         acq_peak_doppler,
   input  gps_chan_pkg::code_shift_t   acq_peak_code_shift,
   input  gps_chan_pkg::code_shift_t   code_shift,
   input  logic [`COUNT_WIDTH-1:0]     sample_count,
   input  logic                        acquisition_complete,
   input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [`AXIL_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready,
   output gps_panel_pkg::seg7_t        hex0,
   output gps_panel_pkg::seg7_t        hex1,
   output gps_panel_pkg::seg7_t        hex2,
   output gps_panel_pkg::seg7_t        hex3,
   output gps_panel_pkg::seg7_t        hex4,
   output gps_panel_pkg::seg7_t        hex5,
   output gps_panel_pkg::seg7_t        hex6,
   output gps_panel_pkg::seg7_t        hex7,
   output logic [17:0]                 ledr,
   output logic [2:0]                  ledg
);

   logic                 clk_sample;
   logic                 ready_flag;
   gps_panel_pkg::seg7_t hex_digits [8];

   chan_report_if chan_if ();

   // Channel results onto the internal bundle
   assign chan_if.i_prompt             = i_prompt;
   assign chan_if.q_prompt             = q_prompt;
   assign chan_if.i2q2_early           = i2q2_early;
   assign chan_if.i2q2_prompt          = i2q2_prompt;
   assign chan_if.i2q2_late            = i2q2_late;
   assign chan_if.carrier_dphi         = carrier_dphi;
   assign chan_if.ca_dphi              = ca_dphi;
   assign chan_if.acq_peak_i2q2        = acq_peak_i2q2;
   assign chan_if.acq_peak_doppler     = acq_peak_doppler;
   assign chan_if.acq_peak_code_shift  = acq_peak_code_shift;
   assign chan_if.code_shift           = code_shift;
   assign chan_if.sample_count         = sample_count;
   assign chan_if.acquisition_complete = acquisition_complete;

   sample_clk_div clk_div_i (
      .clk_16_8   (clk_16_8),
      .rst_n      (rst_n),
      .clk_sample (clk_sample)
   );

   track_ready_stretch stretch_i (
      .clk_16_8       (clk_16_8),
      .rst_n          (rst_n),
      .tracking_ready (tracking_ready),
      .mode           (mode),
      .ready_flag     (ready_flag)
   );

   status_regs_axil regs_i (
      .clk_16_8   (clk_16_8),
      .rst_n      (rst_n),
      .chan       (chan_if.regs),
      .ready_flag (ready_flag),
      .araddr     (araddr),
      .arvalid    (arvalid),
      .arready    (arready),
      .rdata      (rdata),
      .rresp      (rresp),
      .rvalid     (rvalid),
      .rready     (rready)
   );

   hex_page_display disp_i (
      .chan (chan_if.disp),
      .sw   (sw),
      .hex  (hex_digits),
      .ledr (ledr)
   );

   assign hex0 = hex_digits[0];
   assign hex1 = hex_digits[1];
   assign hex2 = hex_digits[2];
   assign hex3 = hex_digits[3];
   assign hex4 = hex_digits[4];
   assign hex5 = hex_digits[5];
   assign hex6 = hex_digits[6];
   assign hex7 = hex_digits[7];  // Most significant nibble

   assign ledg = {acquisition_complete, clk_sample, ready_flag};

endmodule

`default_nettype wire

// ==== logic/hex_page_display.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

module hex_page_display (
   chan_report_if.disp          chan,
   input  logic [17:0]          sw,
   output gps_panel_pkg::seg7_t hex [8],
   output logic [17:0]          ledr
);

   localparam gps_panel_pkg::seg7_t SEG_BLANK = 7'b1111111;

   gps_panel_pkg::disp_page_e page;
   gps_chan_pkg::iq_t         prompt_sel;
   logic [31:0]               disp_value;
   logic [7:4]                digit_lit;

   function automatic gps_panel_pkg::seg7_t hex_glyph(input logic [3:0] nib);
      case (nib)
         4'h0: return 7'b1000000;
         4'h1: return 7'b1111001;
         4'h2: return 7'b0100100;
         4'h3: return 7'b0110000;
         4'h4: return 7'b0011001;
         4'h5: return 7'b0010010;
         4'h6: return 7'b0000010;
         4'h7: return 7'b1111000;
         4'h8: return 7'b0000000;
         4'h9: return 7'b0010000;
         4'hA: return 7'b0001000;
         4'hB: return 7'b0000011;  // Lower case b
         4'hC: return 7'b1000110;
         4'hD: return 7'b0100001;  // Lower case d
         4'hE: return 7'b0000110;
         default: return 7'b0001110;
      endcase
   endfunction

   // Count page first, then acquisition pages, then code shift
   always_comb begin
      if (sw[4])
         page = gps_panel_pkg::PAGE_SAMPLE_COUNT;
      else if (sw[14]) begin
         case (sw[13:12])
            2'd1:    page = gps_panel_pkg::PAGE_ACQ_DOPPLER;
            2'd2:    page = gps_panel_pkg::PAGE_ACQ_CODE;
            default: page = gps_panel_pkg::PAGE_ACQ_I2Q2;
         endcase
      end else if (sw[15])
         page = gps_panel_pkg::PAGE_CODE_SHIFT;
      else
         page = gps_panel_pkg::PAGE_IQ;
   end

   assign prompt_sel = sw[16] ? chan.q_prompt : chan.i_prompt;
   assign ledr       = prompt_sel;

   always_comb begin
      case (page)
         gps_panel_pkg::PAGE_SAMPLE_COUNT: disp_value = 32'(chan.sample_count);
         gps_panel_pkg::PAGE_ACQ_I2Q2:     disp_value = chan.acq_peak_i2q2[`I2Q2_WIDTH-1 -: 32];
         gps_panel_pkg::PAGE_ACQ_DOPPLER:  disp_value = 32'(chan.acq_peak_doppler);
         gps_panel_pkg::PAGE_ACQ_CODE:     disp_value = 32'(chan.acq_peak_code_shift);
         gps_panel_pkg::PAGE_CODE_SHIFT:   disp_value = 32'(chan.code_shift);
         default:                          disp_value = 32'(prompt_sel);
      endcase
   end

   // Upper three digits only carry 32-bit pages
   assign digit_lit[7:5] = (page == gps_panel_pkg::PAGE_SAMPLE_COUNT ||
                            page == gps_panel_pkg::PAGE_ACQ_I2Q2) ? 3'b111 : 3'b000;
   assign digit_lit[4]   = !(page == gps_panel_pkg::PAGE_CODE_SHIFT ||
                             page == gps_panel_pkg::PAGE_ACQ_CODE);

   for (genvar d = 0; d < 8; d++) begin : g_digit
      if (d < 4) begin : g_lit
         assign hex[d] = hex_glyph(disp_value[4*d +: 4]);  // Always lit
      end else begin : g_blankable
         assign hex[d] = digit_lit[d] ? hex_glyph(disp_value[4*d +: 4]) : SEG_BLANK;
      end
   end

endmodule

`default_nettype wire

// ==== logic/status_regs_axil.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

module status_regs_axil (
   input  logic                        clk_16_8,
   input  logic                        rst_n,
   chan_report_if.regs                 chan,
   input  logic                        ready_flag,
   input  logic [`AXIL_ADDR_WIDTH-1:0] araddr,
   input  logic                        arvalid,
   output logic                        arready,
   output logic [`AXIL_DATA_WIDTH-1:0] rdata,
   output logic [1:0]                  rresp,
   output logic                        rvalid,
   input  logic                        rready
);

   localparam logic [1:0] RESP_OKAY   = 2'b00;
   localparam logic [1:0] RESP_SLVERR = 2'b10;

   gps_panel_pkg::axil_state_e  state;
   gps_panel_pkg::status_reg_e  reg_idx;
   logic [`AXIL_DATA_WIDTH-1:0] rd_word;
   logic                        rd_err;

   assign reg_idx = gps_panel_pkg::status_reg_e'(araddr[4:2]);

   // Address decode and read mux
   always_comb begin
      rd_word = '0;
      rd_err  = 1'b0;
      if (araddr[1:0] != 2'b00 || araddr[`AXIL_ADDR_WIDTH-1:5] != '0) begin
         rd_err = 1'b1;  // Misaligned or past 0x1C
      end else begin
         case (reg_idx)
            gps_panel_pkg::REG_FLAGS: begin
               rd_word[0] = ready_flag;
               rd_word[1] = chan.acquisition_complete;
            end
            gps_panel_pkg::REG_I_PROMPT:     rd_word = `AXIL_DATA_WIDTH'(chan.i_prompt);
            gps_panel_pkg::REG_Q_PROMPT:     rd_word = `AXIL_DATA_WIDTH'(chan.q_prompt);
            gps_panel_pkg::REG_I2Q2_EARLY:
               rd_word = chan.i2q2_early[`I2Q2_WIDTH-1 -: `AXIL_DATA_WIDTH];  // Top bits
            gps_panel_pkg::REG_I2Q2_PROMPT:
               rd_word = chan.i2q2_prompt[`I2Q2_WIDTH-1 -: `AXIL_DATA_WIDTH];
            gps_panel_pkg::REG_I2Q2_LATE:
               rd_word = chan.i2q2_late[`I2Q2_WIDTH-1 -: `AXIL_DATA_WIDTH];
            gps_panel_pkg::REG_CARRIER_DPHI: rd_word = `AXIL_DATA_WIDTH'(chan.carrier_dphi);
            gps_panel_pkg::REG_CA_DPHI:      rd_word = `AXIL_DATA_WIDTH'(chan.ca_dphi);
            default:                         rd_word = '0;
         endcase
      end
   end

   assign rvalid = (state == gps_panel_pkg::RD_RESP);

   // One read in flight, arready held low until the response is taken
   always_ff @(posedge clk_16_8) begin
      if (!rst_n) begin
         state   <= gps_panel_pkg::RD_IDLE;
         arready <= 1'b0;
      end else begin
         case (state)
            gps_panel_pkg::RD_IDLE: begin
               if (arvalid && arready) begin
                  state   <= gps_panel_pkg::RD_RESP;
                  arready <= 1'b0;
               end else begin
                  arready <= 1'b1;
               end
            end
            gps_panel_pkg::RD_RESP: begin
               if (rready) begin
                  state   <= gps_panel_pkg::RD_IDLE;
                  arready <= 1'b1;
               end
            end
            default: state <= gps_panel_pkg::RD_IDLE;
         endcase
      end
   end

   // Response payload, captured on the AR handshake only
   always_ff @(posedge clk_16_8) begin
      if (state == gps_panel_pkg::RD_IDLE && arvalid && arready) begin
         rdata <= rd_word;
         rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
      end
   end

endmodule

`default_nettype wire

// ==== logic/track_ready_stretch.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

module track_ready_stretch (
   input  logic                   clk_16_8,
   input  logic                   rst_n,
   input  logic                   tracking_ready,
   input  gps_chan_pkg::rx_mode_e mode,
   output logic                   ready_flag
);

   localparam int HOLD_W = $clog2(`READY_HOLD + 1);

   logic [HOLD_W-1:0] hold_cnt;

   // A one-cycle pulse from the channel is too short for a polling host
   always_ff @(posedge clk_16_8) begin
      if (!rst_n) begin
         hold_cnt   <= '0;
         ready_flag <= 1'b0;
      end else begin
         if (tracking_ready)
            hold_cnt <= HOLD_W'(`READY_HOLD);  // Retrigger restarts the hold
         else if (hold_cnt != '0)
            hold_cnt <= hold_cnt - 1'b1;

         if (tracking_ready && mode == gps_chan_pkg::MODE_TRACK)
            ready_flag <= 1'b1;
         else if (hold_cnt == '0)
            ready_flag <= 1'b0;  // Drops one cycle after count reaches zero
      end
   end

endmodule

`default_nettype wire

// ==== logic/sample_clk_div.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

module sample_clk_div (
   input  logic clk_16_8,
   input  logic rst_n,
   output logic clk_sample
);

   localparam int CNT_W = $clog2(`SAMPLE_DIV_RELOAD + 1);

   logic [CNT_W-1:0] div_cnt;

   always_ff @(posedge clk_16_8) begin
      if (!rst_n) begin
         div_cnt    <= CNT_W'(`SAMPLE_DIV_RELOAD);
         clk_sample <= 1'b0;
      end else if (div_cnt == '0) begin
         div_cnt    <= CNT_W'(`SAMPLE_DIV_RELOAD);  // Half period is reload + 1
         clk_sample <= ~clk_sample;
      end else begin
         div_cnt <= div_cnt - 1'b1;
      end
   end

endmodule

`default_nettype wire

// ==== logic/chan_report_if.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "gps_panel_macros.svh"

interface chan_report_if;
   gps_chan_pkg::iq_t         i_prompt;
   gps_chan_pkg::iq_t         q_prompt;
   gps_chan_pkg::i2q2_t       i2q2_early;
   gps_chan_pkg::i2q2_t       i2q2_prompt;
   gps_chan_pkg::i2q2_t       i2q2_late;
   gps_chan_pkg::dphi_t       carrier_dphi;
   gps_chan_pkg::dphi_t       ca_dphi;
   gps_chan_pkg::i2q2_t       acq_peak_i2q2;
   gps_chan_pkg::dphi_t       acq_peak_doppler;
   gps_chan_pkg::code_shift_t acq_peak_code_shift;
   gps_chan_pkg::code_shift_t code_shift;
   logic [`COUNT_WIDTH-1:0]   sample_count;
   logic                      acquisition_complete;

   modport source (output i_prompt, q_prompt, i2q2_early, i2q2_prompt, i2q2_late,
                   carrier_dphi, ca_dphi, acq_peak_i2q2, acq_peak_doppler,
                   acq_peak_code_shift, code_shift, sample_count, acquisition_complete);
   modport regs (input i_prompt, q_prompt, i2q2_early, i2q2_prompt, i2q2_late,
                 carrier_dphi, ca_dphi, acquisition_complete);
   modport disp (input i_prompt, q_prompt, acq_peak_i2q2, acq_peak_doppler,
                 acq_peak_code_shift, code_shift, sample_count);
endinterface

`default_nettype wire

// ==== logic/gps_panel_pkg.sv ====
`default_nettype none

package gps_panel_pkg;

   // Pages of the eight-digit hex display
   typedef enum logic [2:0] {
      PAGE_IQ,
      PAGE_CODE_SHIFT,
      PAGE_SAMPLE_COUNT,
      PAGE_ACQ_I2Q2,
      PAGE_ACQ_DOPPLER,
      PAGE_ACQ_CODE
   } disp_page_e;

   // Word index of the status registers, byte address is index * 4
   typedef enum logic [2:0] {
      REG_FLAGS        = 3'd0,
      REG_I_PROMPT     = 3'd1,
      REG_Q_PROMPT     = 3'd2,
      REG_I2Q2_EARLY   = 3'd3,
      REG_I2Q2_PROMPT  = 3'd4,
      REG_I2Q2_LATE    = 3'd5,
      REG_CARRIER_DPHI = 3'd6,
      REG_CA_DPHI      = 3'd7
   } status_reg_e;

   typedef enum logic {RD_IDLE, RD_RESP} axil_state_e;

   typedef logic [6:0] seg7_t;  // Active low, bit 6 is g, bit 0 is a

endpackage

`default_nettype wire

// ==== logic/gps_chan_pkg.sv ====
`default_nettype none

`include "gps_panel_macros.svh"

package gps_chan_pkg;

   // Receiver mode as driven by the channel controller
   typedef enum logic {
      MODE_ACQ   = 1'b0,  // Acquisition search
      MODE_TRACK = 1'b1   // Closed-loop tracking
   } rx_mode_e;

   typedef logic [`I2Q2_WIDTH-1:0] i2q2_t;        // Power value
   typedef logic [`IQ_WIDTH-1:0]   iq_t;          // Prompt sum
   typedef logic [`DPHI_WIDTH-1:0] dphi_t;        // Phase increment
   typedef logic [`CS_WIDTH-1:0]   code_shift_t;  // Code shift in chips

endpackage

`default_nettype wire

// ==== include/gps_panel_macros.svh ====
`ifndef GPS_PANEL_MACROS_SVH
`define GPS_PANEL_MACROS_SVH

// Channel result widths
`define I2Q2_WIDTH        38  // Early, prompt and late power
`define IQ_WIDTH          18  // Prompt I and Q sums
`define DPHI_WIDTH        17  // Carrier and code phase increments
`define CS_WIDTH          15  // Code shift
`define COUNT_WIDTH       32  // Synchronised sample count

// Divider and stretcher reload values
`define SAMPLE_DIV_RELOAD 8   // 16.8 MHz / 18 sample clock
`define READY_HOLD        15  // Hold for 16 cycles in total

// Host status bus
`define AXIL_ADDR_WIDTH   8
`define AXIL_DATA_WIDTH   32

`endif
